/* rtl/sram_pkg.sv */
`default_nettype none

package sram_pkg;

  // sram geometry
  localparam int SRAM_AW = 10;
  localparam int SRAM_DW = 16;

  // axi4-lite geometry, 1024 words of 4 bytes
  localparam int AXI_AW = 12;
  localparam int AXI_DW = 32;
  localparam int AXI_SW = AXI_DW / 8;

  typedef logic [SRAM_AW-1:0] sram_addr_t;
  typedef logic [SRAM_DW-1:0] sram_data_t;
  typedef logic [AXI_AW-1:0]  axi_addr_t;
  typedef logic [AXI_DW-1:0]  axi_data_t;
  typedef logic [AXI_SW-1:0]  axi_strb_t;
  typedef logic [1:0]         axi_resp_t;

  // response codes used on b and r
  localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
  localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;

  // one sram access, 27 bits
  typedef struct packed {
    logic       wr;
    sram_addr_t addr;
    sram_data_t wdata;
  } sram_req_t;

  // read result, only meaningful for reads
  typedef struct packed {
    sram_data_t rdata;
  } sram_rsp_t;

  typedef enum logic [2:0] {
    AXIL_IDLE,
    AXIL_WR_ACCEPT,
    AXIL_ISSUE,
    AXIL_WAIT,
    AXIL_WR_RESP,
    AXIL_RD_RESP
  } axil_state_e;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_WR_SETUP,
    CTRL_WR_STROBE,
    CTRL_WR_HOLD,
    CTRL_RD_STROBE,
    CTRL_RD_WAIT
  } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/axil_sram_slave.sv */
`default_nettype none

module axil_sram_slave
  import sram_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // axi4-lite write channels
  input  axi_addr_t  s_awaddr,
  input  logic       s_awvalid,
  output logic       s_awready,
  input  axi_data_t  s_wdata,
  input  axi_strb_t  s_wstrb,
  input  logic       s_wvalid,
  output logic       s_wready,
  output axi_resp_t  s_bresp,
  output logic       s_bvalid,
  input  logic       s_bready,

  // axi4-lite read channels
  input  axi_addr_t  s_araddr,
  input  logic       s_arvalid,
  output logic       s_arready,
  output axi_data_t  s_rdata,
  output axi_resp_t  s_rresp,
  output logic       s_rvalid,
  input  logic       s_rready,

  // request toward the controller
  output sram_req_t  req,
  output logic       req_valid,
  input  logic       req_ready,
  input  logic       done,
  input  sram_rsp_t  rsp
);

  axil_state_e state;

  // held transaction
  sram_addr_t  addr_q;
  sram_data_t  wdata_q;
  logic        strb_ok_q;
  logic        is_wr_q;
  logic        aw_held;
  logic        w_held;
  axi_resp_t   bresp_q;
  axi_data_t   rdata_q;

  logic        aw_fire;
  logic        w_fire;
  logic        ar_fire;
  logic        aw_done;
  logic        w_done;
  logic        strb_ok;

  // aw and w are only taken once a write has been picked in idle
  assign s_awready = (state == AXIL_WR_ACCEPT) && !aw_held;
  assign s_wready  = (state == AXIL_WR_ACCEPT) && !w_held;
  // a read is taken only when no write is pending, writes win
  assign s_arready = (state == AXIL_IDLE) && s_arvalid && !s_awvalid && !s_wvalid;

  assign aw_fire = s_awvalid && s_awready;
  assign w_fire  = s_wvalid && s_wready;
  assign ar_fire = s_arvalid && s_arready;

  // a channel counts as done in the cycle of its handshake too
  assign aw_done = aw_held || aw_fire;
  assign w_done  = w_held || w_fire;

  // chip has no byte lanes, need both low strobes for a write
  assign strb_ok = w_held ? strb_ok_q : (s_wstrb[1:0] == 2'b11);

  assign req_valid = (state == AXIL_ISSUE);
  assign req       = '{wr: is_wr_q, addr: addr_q, wdata: wdata_q};

  // responses stay up until the master takes them
  assign s_bvalid = (state == AXIL_WR_RESP);
  assign s_bresp  = bresp_q;
  assign s_rvalid = (state == AXIL_RD_RESP);
  assign s_rdata  = rdata_q;
  assign s_rresp  = AXI_RESP_OKAY;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= AXIL_IDLE;
      is_wr_q <= 1'b0;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
    end else begin
      case (state)
        AXIL_IDLE: begin
          if (s_awvalid || s_wvalid) begin
            state   <= AXIL_WR_ACCEPT;
            is_wr_q <= 1'b1;
          end else if (ar_fire) begin
            state   <= AXIL_ISSUE;
            is_wr_q <= 1'b0;
          end
        end
        AXIL_WR_ACCEPT: begin
          if (aw_fire) begin
            aw_held <= 1'b1;
          end
          if (w_fire) begin
            w_held <= 1'b1;
          end
          // both halves in, either go to the sram or reject right away
          if (aw_done && w_done) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            state   <= strb_ok ? AXIL_ISSUE : AXIL_WR_RESP;
          end
        end
        AXIL_ISSUE: begin
          if (req_ready) begin
            state <= AXIL_WAIT;
          end
        end
        AXIL_WAIT: begin
          if (done) begin
            state <= is_wr_q ? AXIL_WR_RESP : AXIL_RD_RESP;
          end
        end
        AXIL_WR_RESP: begin
          if (s_bready) begin
            state <= AXIL_IDLE;
          end
        end
        AXIL_RD_RESP: begin
          if (s_rready) begin
            state <= AXIL_IDLE;
          end
        end
        default: begin
          state <= AXIL_IDLE;
        end
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    // byte address to word address
    if (aw_fire) begin
      addr_q <= s_awaddr[AXI_AW-1:AXI_AW-SRAM_AW];
    end else if (ar_fire) begin
      addr_q <= s_araddr[AXI_AW-1:AXI_AW-SRAM_AW];
    end
    // only the low half of the bus reaches the chip
    if (w_fire) begin
      wdata_q   <= s_wdata[SRAM_DW-1:0];
      strb_ok_q <= (s_wstrb[1:0] == 2'b11);
    end
    // b code is fixed when the write is decided
    if (state == AXIL_WR_ACCEPT && aw_done && w_done) begin
      bresp_q <= strb_ok ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
    // zero extend the sram word
    if (state == AXIL_WAIT && done && !is_wr_q) begin
      rdata_q <= {{(AXI_DW-SRAM_DW){1'b0}}, rsp.rdata};
    end
  end

endmodule

`default_nettype wire

/* rtl/sram_ctrl.sv */
`default_nettype none

module sram_ctrl
  import sram_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // request from the slave
  input  sram_req_t  req,
  input  logic       req_valid,
  output logic       req_ready,
  output logic       done,
  output sram_rsp_t  rsp,

  // toward the pad block
  output sram_addr_t pad_addr,
  output sram_data_t pad_wr_data,
  output logic       pad_wr_en,
  output logic       pad_we_n,
  output logic       pad_oe_n,
  input  logic       pad_rd_valid,
  input  sram_data_t pad_rd_data
);

  ctrl_state_e state;
  sram_req_t   req_q;

  // marks the second cycle of the oe strobe
  logic        rd_cnt;
  // write completion, one cycle after hold
  logic        done_wr;
  // first returning sample ends the read
  logic        rd_hit;

  assign req_ready = (state == CTRL_IDLE);
  assign rd_hit    = (state == CTRL_RD_WAIT) && pad_rd_valid;
  assign done      = done_wr || rd_hit;

  // pad block holds the captured word until the next oe sample
  assign rsp = '{rdata: pad_rd_data};

  // address and write data stay put for the whole access
  assign pad_addr    = req_q.addr;
  assign pad_wr_data = req_q.wdata;

  // bus driven through setup, strobe and hold
  assign pad_wr_en = (state == CTRL_WR_SETUP) ||
                     (state == CTRL_WR_STROBE) ||
                     (state == CTRL_WR_HOLD);
  // we and oe come from different states, never low together
  assign pad_we_n = (state != CTRL_WR_STROBE);
  assign pad_oe_n = (state != CTRL_RD_STROBE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= CTRL_IDLE;
      rd_cnt  <= 1'b0;
      done_wr <= 1'b0;
    end else begin
      done_wr <= (state == CTRL_WR_HOLD);
      case (state)
        CTRL_IDLE: begin
          if (req_valid) begin
            state <= req.wr ? CTRL_WR_SETUP : CTRL_RD_STROBE;
          end
        end
        // one cycle each for setup, we low and hold
        CTRL_WR_SETUP: begin
          state <= CTRL_WR_STROBE;
        end
        CTRL_WR_STROBE: begin
          state <= CTRL_WR_HOLD;
        end
        CTRL_WR_HOLD: begin
          state <= CTRL_IDLE;
        end
        // oe low for two cycles
        CTRL_RD_STROBE: begin
          rd_cnt <= !rd_cnt;
          if (rd_cnt) begin
            state <= CTRL_RD_WAIT;
          end
        end
        // wait out the pad register stage
        CTRL_RD_WAIT: begin
          if (pad_rd_valid) begin
            state <= CTRL_IDLE;
          end
        end
        default: begin
          state <= CTRL_IDLE;
        end
      endcase
    end
  end

  // latch the request on the handshake
  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      req_q <= req;
    end
  end

endmodule

`default_nettype wire

/* rtl/sram_pad_io.sv */
`default_nettype none

module sram_pad_io
  import sram_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // controller side
  input  sram_addr_t pad_addr,
  input  sram_data_t pad_wr_data,
  input  logic       pad_wr_en,
  input  logic       pad_we_n,
  input  logic       pad_oe_n,
  output logic       pad_rd_valid,
  output sram_data_t pad_rd_data,

  // chip side, data bus split into out, enable and in
  output sram_addr_t sram_addr,
  output sram_data_t sram_wr_data,
  output logic       sram_data_oe,
  output logic       sram_we_n,
  output logic       sram_oe_n,
  output logic       sram_ce_n,
  input  sram_data_t sram_rd_data
);

  sram_addr_t addr_q;
  sram_data_t wr_data_q;
  logic       data_oe_q;
  logic       we_n_q;
  logic       oe_n_q;

  // chip stays deselected while in reset so it cannot fight the bus
  assign sram_ce_n = !rst_n;

  assign sram_addr    = addr_q;
  assign sram_wr_data = wr_data_q;
  assign sram_data_oe = data_oe_q;
  assign sram_we_n    = we_n_q;
  assign sram_oe_n    = oe_n_q;

  // strobes and bus drive forced inactive in reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_oe_q <= 1'b0;
      we_n_q    <= 1'b1;
      oe_n_q    <= 1'b1;
    end else begin
      data_oe_q <= pad_wr_en;
      we_n_q    <= pad_we_n;
      oe_n_q    <= pad_oe_n;
    end
  end

  // address and data follow one cycle later
  always_ff @(posedge clk) begin
    addr_q    <= pad_addr;
    wr_data_q <= pad_wr_data;
  end

  // one valid per edge that saw oe low on the pin
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pad_rd_valid <= 1'b0;
    end else begin
      pad_rd_valid <= !oe_n_q;
    end
  end

  // read sample, held between captures
  always_ff @(posedge clk) begin
    if (!oe_n_q) begin
      pad_rd_data <= sram_rd_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/sram_subsys_top.sv */
`default_nettype none

module sram_subsys_top
  import sram_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // axi4-lite slave port
  input  axi_addr_t  s_awaddr,
  input  logic       s_awvalid,
  output logic       s_awready,
  input  axi_data_t  s_wdata,
  input  axi_strb_t  s_wstrb,
  input  logic       s_wvalid,
  output logic       s_wready,
  output axi_resp_t  s_bresp,
  output logic       s_bvalid,
  input  logic       s_bready,
  input  axi_addr_t  s_araddr,
  input  logic       s_arvalid,
  output logic       s_arready,
  output axi_data_t  s_rdata,
  output axi_resp_t  s_rresp,
  output logic       s_rvalid,
  input  logic       s_rready,

  // sram pins
  output sram_addr_t sram_addr,
  output sram_data_t sram_wr_data,
  output logic       sram_data_oe,
  input  sram_data_t sram_rd_data,
  output logic       sram_we_n,
  output logic       sram_oe_n,
  output logic       sram_ce_n
);

  // slave to controller
  sram_req_t  req;
  logic       req_valid;
  logic       req_ready;
  logic       done;
  sram_rsp_t  rsp;

  // controller to pads
  sram_addr_t pad_addr;
  sram_data_t pad_wr_data;
  logic       pad_wr_en;
  logic       pad_we_n;
  logic       pad_oe_n;
  logic       pad_rd_valid;
  sram_data_t pad_rd_data;

  axil_sram_slave i_axil_sram_slave (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_awaddr  (s_awaddr),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_bresp   (s_bresp),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_araddr  (s_araddr),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .done      (done),
    .rsp       (rsp)
  );

  sram_ctrl i_sram_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .done         (done),
    .rsp          (rsp),
    .pad_addr     (pad_addr),
    .pad_wr_data  (pad_wr_data),
    .pad_wr_en    (pad_wr_en),
    .pad_we_n     (pad_we_n),
    .pad_oe_n     (pad_oe_n),
    .pad_rd_valid (pad_rd_valid),
    .pad_rd_data  (pad_rd_data)
  );

  sram_pad_io i_sram_pad_io (
    .clk          (clk),
    .rst_n        (rst_n),
    .pad_addr     (pad_addr),
    .pad_wr_data  (pad_wr_data),
    .pad_wr_en    (pad_wr_en),
    .pad_we_n     (pad_we_n),
    .pad_oe_n     (pad_oe_n),
    .pad_rd_valid (pad_rd_valid),
    .pad_rd_data  (pad_rd_data),
    .sram_addr    (sram_addr),
    .sram_wr_data (sram_wr_data),
    .sram_data_oe (sram_data_oe),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n),
    .sram_rd_data (sram_rd_data)
  );

endmodule

`default_nettype wire

/* tb/sram_chip_model.sv */
`default_nettype none

module sram_chip_model
  import sram_pkg::*;
(
  input  sram_addr_t sram_addr,
  input  sram_data_t sram_wr_data,
  input  logic       sram_data_oe,
  output sram_data_t sram_rd_data,
  input  logic       sram_we_n,
  input  logic       sram_oe_n,
  input  logic       sram_ce_n,
  output logic       bus_conflict
);

  sram_data_t mem [0:(2**SRAM_AW)-1];
  logic       chip_drive;
  sram_data_t bus;

  // power-up contents, every address bit takes part
  function automatic sram_data_t fill_word(input sram_addr_t a);
    return {a[3:0], a[9:0], a[5:4]} ^ 16'h6b1d;
  endfunction

  initial begin
    for (int i = 0; i < 2**SRAM_AW; i++) begin
      mem[i] = fill_word(sram_addr_t'(i));
    end
  end

  // chip drives the bus when selected, oe low and not writing
  assign chip_drive   = !sram_ce_n && !sram_oe_n && sram_we_n;
  // both sides driving at once is a fight on the real pins
  assign bus_conflict = chip_drive && sram_data_oe;

  // resolved bus, controller side first, floating bus reads as zero
  assign bus          = sram_data_oe ? sram_wr_data : (chip_drive ? mem[sram_addr] : '0);
  assign sram_rd_data = bus;

  // async write, data taken at the end of the we pulse
  always @(posedge sram_we_n) begin
    if (!sram_ce_n) begin
      mem[sram_addr] = bus;
    end
  end

endmodule

`default_nettype wire

/* tb/sram_props.sv */
`default_nettype none

module sram_props (
  input logic clk,
  input logic rst_n,
  input logic sram_we_n,
  input logic sram_oe_n,
  input logic sram_data_oe,
  input logic sram_ce_n,
  input logic pad_rd_valid
);

  // write and read strobes never overlap on the pins
  we_oe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(!sram_we_n && !sram_oe_n))
    else $error("we_n and oe_n low in the same cycle");

  // bus is driven for the whole write pulse
  drive_during_we: assert property (@(posedge clk) disable iff (!rst_n)
    !sram_we_n |-> sram_data_oe)
    else $error("we_n low without data_oe");

  // chip deselected and registered strobes idle once a reset edge has passed
  reset_pins_idle: assert property (@(posedge clk)
    !rst_n && $past(!rst_n) |-> sram_ce_n && sram_we_n && sram_oe_n && !sram_data_oe)
    else $error("pins not idle during reset");

  // each capture strobe comes from an oe sample one cycle back, bus released
  rd_valid_source: assert property (@(posedge clk) disable iff (!rst_n)
    pad_rd_valid |-> $past(!sram_oe_n && !sram_data_oe))
    else $error("pad_rd_valid without a clean oe_n sample");

endmodule

bind sram_pad_io sram_props i_sram_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .sram_we_n    (sram_we_n),
  .sram_oe_n    (sram_oe_n),
  .sram_data_oe (sram_data_oe),
  .sram_ce_n    (sram_ce_n),
  .pad_rd_valid (pad_rd_valid)
);

`default_nettype wire

/* tb/tb_sram_subsys.sv */
`default_nettype none

module tb_sram_subsys
  import sram_pkg::*;
();

  localparam int CLK_PERIOD     = 10;
  localparam int NUM_RANDOM     = 200;
  localparam int NUM_DIRECTED   = 24;
  // per transaction budget, leaves room for ready stalls
  localparam int CYCLES_PER_TXN = 60;
  localparam int TIMEOUT_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * CYCLES_PER_TXN + 100;

  // axi response codes
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  logic       clk = 1'b0;
  logic       rst_n;

  axi_addr_t  s_awaddr;
  logic       s_awvalid;
  logic       s_awready;
  axi_data_t  s_wdata;
  axi_strb_t  s_wstrb;
  logic       s_wvalid;
  logic       s_wready;
  axi_resp_t  s_bresp;
  logic       s_bvalid;
  logic       s_bready;
  axi_addr_t  s_araddr;
  logic       s_arvalid;
  logic       s_arready;
  axi_data_t  s_rdata;
  axi_resp_t  s_rresp;
  logic       s_rvalid;
  logic       s_rready;

  sram_addr_t sram_addr;
  sram_data_t sram_wr_data;
  logic       sram_data_oe;
  sram_data_t sram_rd_data;
  logic       sram_we_n;
  logic       sram_oe_n;
  logic       sram_ce_n;
  logic       bus_conflict;

  // reference memory and expected responses in issue order
  sram_data_t ref_mem [0:(2**SRAM_AW)-1];
  axi_resp_t  exp_bresp [$];
  axi_data_t  exp_rdata [$];
  axi_resp_t  exp_b;
  axi_data_t  exp_r;

  logic [31:0] rng_state;
  logic        stall_en;
  int          err_count;
  int          check_count;

  // stall tracking for response stability
  logic        b_stalled;
  logic        r_stalled;
  axi_resp_t   b_held;
  axi_data_t   r_held;

  always #(CLK_PERIOD / 2) clk = ~clk;

  sram_subsys_top i_sram_subsys_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_awaddr     (s_awaddr),
    .s_awvalid    (s_awvalid),
    .s_awready    (s_awready),
    .s_wdata      (s_wdata),
    .s_wstrb      (s_wstrb),
    .s_wvalid     (s_wvalid),
    .s_wready     (s_wready),
    .s_bresp      (s_bresp),
    .s_bvalid     (s_bvalid),
    .s_bready     (s_bready),
    .s_araddr     (s_araddr),
    .s_arvalid    (s_arvalid),
    .s_arready    (s_arready),
    .s_rdata      (s_rdata),
    .s_rresp      (s_rresp),
    .s_rvalid     (s_rvalid),
    .s_rready     (s_rready),
    .sram_addr    (sram_addr),
    .sram_wr_data (sram_wr_data),
    .sram_data_oe (sram_data_oe),
    .sram_rd_data (sram_rd_data),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n)
  );

  sram_chip_model i_sram_chip_model (
    .sram_addr    (sram_addr),
    .sram_wr_data (sram_wr_data),
    .sram_data_oe (sram_data_oe),
    .sram_rd_data (sram_rd_data),
    .sram_we_n    (sram_we_n),
    .sram_oe_n    (sram_oe_n),
    .sram_ce_n    (sram_ce_n),
    .bus_conflict (bus_conflict)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = lcg_step(rng_state);
    r = rng_state;
  endtask

  // expected power-up contents of the chip
  function automatic sram_data_t initial_word(input sram_addr_t a);
    return {a[3:0], a[9:0], a[5:4]} ^ 16'h6b1d;
  endfunction

  // no byte lanes on the chip, anything short of both low bytes is refused
  function automatic axi_resp_t expect_bresp(input axi_strb_t strb);
    return (strb[1:0] == 2'b11) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  // word address is byte address over 4, upper half zero
  function automatic axi_data_t expect_rdata(input axi_addr_t addr);
    return {16'h0000, ref_mem[addr[11:2]]};
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    check_count++;
    assert (got == exp) else begin
      err_count++;
      $display("ERROR at time %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic pick_ready(output logic rdy);
    logic [31:0] r;
    if (!stall_en) begin
      rdy = 1'b1;
    end else begin
      // high three times out of four
      next_rand(r);
      rdy = (r[17:16] != 2'b00);
    end
  endtask

  task automatic wait_bresp();
    logic rdy;
    logic got;
    got = 1'b0;
    pick_ready(rdy);
    s_bready <= rdy;
    while (!got) begin
      @(posedge clk);
      if (s_bvalid && s_bready) begin
        got = 1'b1;
        s_bready <= 1'b0;
      end else begin
        pick_ready(rdy);
        s_bready <= rdy;
      end
    end
  endtask

  task automatic wait_rresp();
    logic rdy;
    logic got;
    got = 1'b0;
    pick_ready(rdy);
    s_rready <= rdy;
    while (!got) begin
      @(posedge clk);
      if (s_rvalid && s_rready) begin
        got = 1'b1;
        s_rready <= 1'b0;
      end else begin
        pick_ready(rdy);
        s_rready <= rdy;
      end
    end
  endtask

  // order 0 aw before w, 1 w before aw, 2 both together
  task automatic write_word(input axi_addr_t addr, input axi_data_t data,
                            input axi_strb_t strb, input int order);
    logic aw_todo;
    logic w_todo;
    exp_bresp.push_back(expect_bresp(strb));
    if (strb[1:0] == 2'b11) begin
      ref_mem[addr[11:2]] = data[15:0];
    end
    aw_todo = 1'b1;
    w_todo  = 1'b1;
    @(posedge clk);
    s_awaddr  <= addr;
    s_wdata   <= data;
    s_wstrb   <= strb;
    s_awvalid <= (order != 1);
    s_wvalid  <= (order != 0);
    while (aw_todo || w_todo) begin
      @(posedge clk);
      if (s_awvalid && s_awready) begin
        aw_todo = 1'b0;
        s_awvalid <= 1'b0;
      end
      if (s_wvalid && s_wready) begin
        w_todo = 1'b0;
        s_wvalid <= 1'b0;
      end
      // second channel goes up once the first one has transferred
      if (!aw_todo && w_todo && !s_wvalid) begin
        s_wvalid <= 1'b1;
      end
      if (!w_todo && aw_todo && !s_awvalid) begin
        s_awvalid <= 1'b1;
      end
    end
    wait_bresp();
  endtask

  task automatic read_word(input axi_addr_t addr);
    logic got;
    exp_rdata.push_back(expect_rdata(addr));
    got = 1'b0;
    @(posedge clk);
    s_araddr  <= addr;
    s_arvalid <= 1'b1;
    while (!got) begin
      @(posedge clk);
      if (s_arvalid && s_arready) begin
        got = 1'b1;
        s_arvalid <= 1'b0;
      end
    end
    wait_rresp();
  endtask

  task automatic check_reset_state();
    check_value(32'(s_awready), 32'd0, "awready after reset");
    check_value(32'(s_wready), 32'd0, "wready after reset");
    check_value(32'(s_arready), 32'd0, "arready after reset");
    check_value(32'(s_bvalid), 32'd0, "bvalid after reset");
    check_value(32'(s_rvalid), 32'd0, "rvalid after reset");
    check_value(32'(i_sram_subsys_top.req_valid), 32'd0, "req_valid after reset");
    check_value(32'(sram_we_n), 32'd1, "we_n after reset");
    check_value(32'(sram_oe_n), 32'd1, "oe_n after reset");
    check_value(32'(sram_data_oe), 32'd0, "data_oe after reset");
  endtask

  // compares every b and r handshake, and holds responses steady under stall
  always @(posedge clk) begin
    if (rst_n) begin
      check_value(32'(bus_conflict), 32'd0, "data bus contention");
      if (b_stalled) begin
        check_value(32'(s_bvalid), 32'd1, "bvalid dropped while stalled");
        check_value(32'(s_bresp), 32'(b_held), "bresp changed while stalled");
      end
      if (r_stalled) begin
        check_value(32'(s_rvalid), 32'd1, "rvalid dropped while stalled");
        check_value(s_rdata, r_held, "rdata changed while stalled");
      end
      if (s_bvalid && s_bready) begin
        assert (exp_bresp.size() != 0) else begin
          err_count++;
          $display("write response arrived at time %0t with no write outstanding", $time);
        end
        if (exp_bresp.size() != 0) begin
          exp_b = exp_bresp.pop_front();
          check_value(32'(s_bresp), 32'(exp_b), "bresp");
        end
      end
      if (s_rvalid && s_rready) begin
        assert (exp_rdata.size() != 0) else begin
          err_count++;
          $display("read response arrived at time %0t with no read outstanding", $time);
        end
        if (exp_rdata.size() != 0) begin
          exp_r = exp_rdata.pop_front();
          check_value(s_rdata, exp_r, "rdata");
          check_value(32'(s_rresp), 32'(RESP_OKAY), "rresp");
        end
      end
    end
    b_stalled <= rst_n && s_bvalid && !s_bready;
    r_stalled <= rst_n && s_rvalid && !s_rready;
    b_held    <= s_bresp;
    r_held    <= s_rdata;
  end

  initial begin
    logic [31:0] r;
    axi_addr_t   a;
    axi_data_t   d;
    axi_strb_t   s;
    int          ord;
    rng_state   = 32'hc8e96dee;
    stall_en    = 1'b0;
    err_count   = 0;
    check_count = 0;
    for (int i = 0; i < 2**SRAM_AW; i++) begin
      ref_mem[i] = initial_word(sram_addr_t'(i));
    end
    rst_n     <= 1'b0;
    s_awaddr  <= '0;
    s_awvalid <= 1'b0;
    s_wdata   <= '0;
    s_wstrb   <= '0;
    s_wvalid  <= 1'b0;
    s_bready  <= 1'b0;
    s_araddr  <= '0;
    s_arvalid <= 1'b0;
    s_rready  <= 1'b0;

    // two cycles of reset, chip must stay deselected
    repeat (2) @(posedge clk);
    check_value(32'(sram_ce_n), 32'd1, "ce_n during reset");
    rst_n <= 1'b1;
    @(posedge clk);
    check_reset_state();

    // write then read back
    write_word(12'h124, 32'hbeef_1234, 4'hf, 2);
    read_word(12'h124);

    // partial strobes refused, memory keeps the old word
    write_word(12'h124, 32'h0000_5678, 4'b0001, 2);
    write_word(12'h124, 32'h0000_9abc, 4'b1110, 0);
    write_word(12'h124, 32'h0000_def0, 4'b1100, 1);
    read_word(12'h124);

    // aw first, w first, both together
    write_word(12'h200, 32'h1111_a001, 4'hf, 0);
    write_word(12'h204, 32'h2222_b002, 4'hf, 1);
    write_word(12'h208, 32'h3333_c003, 4'hf, 2);
    read_word(12'h200);
    read_word(12'h204);
    read_word(12'h208);

    // both ends of the address range
    write_word(12'h000, 32'h0000_0f0f, 4'hf, 2);
    write_word(12'hffc, 32'h0000_f0f0, 4'hf, 2);
    read_word(12'h000);
    read_word(12'hffc);
    write_word(12'h000, 32'h0000_55aa, 4'hf, 0);
    read_word(12'hffc);
    read_word(12'h000);

    // random mix with stalls on bready and rready
    stall_en = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      next_rand(r);
      // half of the traffic lands in a small window so reads hit writes
      a   = {(r[20] ? r[9:0] : {4'h0, r[5:0]}), 2'b00};
      s   = (r[23:22] == 2'b00) ? r[27:24] : 4'hf;
      ord = int'(r[31:29]) % 3;
      next_rand(d);
      if (r[12]) begin
        write_word(a, d, s, ord);
      end else begin
        read_word(a);
      end
    end
    stall_en = 1'b0;
    @(posedge clk);

    assert (exp_bresp.size() == 0 && exp_rdata.size() == 0) else begin
      err_count++;
      $display("some expected responses never arrived");
    end
    $display("checks run: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog, bounded by the transaction count
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, a handshake never completed",
             TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
rtl/sram_pkg.sv
rtl/axil_sram_slave.sv
rtl/sram_ctrl.sv
rtl/sram_pad_io.sv
rtl/sram_subsys_top.sv
tb/sram_chip_model.sv
tb/sram_props.sv
tb/tb_sram_subsys.sv

/* run.sh */
#!/bin/sh
# build and run the sram subsystem testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_sram_subsys

out="$(./obj_dir/Vtb_sram_subsys)"
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -qx "Simulation finished: PASS"
